// File: sources.f
logic/cache_pkg.sv
logic/cache_ctrl.sv
logic/cache_dpath.sv
logic/blocking_cache.sv
testbench/cache_sva.sv
testbench/cache_tb.sv

// File: Makefile
# Verilator build and run of the cache testbench

TOP := cache_tb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: testbench/cache_tests.txt
# op opaque addr wdata expected (hex; expected is 0 for write and init)
# 256-byte cache: index is addr[7:4], tag is addr[31:8]
init  01 00000100 11112222 00000000
read  02 00000100 00000000 11112222
read  03 00000230 00000000 c0de0230
write 04 00000234 aabbccdd 00000000
read  05 00000230 00000000 c0de0230
read  06 00000234 00000000 aabbccdd
read  07 00000238 00000000 c0de0238
read  08 0000023c 00000000 c0de023c
read  09 00001238 00000000 c0de1238
read  0a 00000234 00000000 aabbccdd
write 0b 00000548 0000beef 00000000
read  0c 00001544 00000000 c0de1544
read  0d 00000548 00000000 0000beef
read  0e 0000054c 00000000 c0de054c
write 0f 0000ff70 12345678 00000000
read  10 0000ff70 00000000 12345678
read  11 00000100 00000000 11112222

// File: testbench/cache_tb.sv
/*
 * Testbench for the blocking cache. Runs the requests in cache_tests.txt
 * against a main memory model with random latency and a shadow tag model.
 */

`timescale 1ns/1ps

module cache_tb;

  localparam int cache_bytes = 256;
  localparam int nblocks     = cache_bytes * 8 / cache_pkg::line_w;
  localparam int idx_w       = $clog2(nblocks);
  localparam int max_wait    = 200;

  logic                   clk;
  logic                   rst_n;
  cache_pkg::cache_req_t  cache_req;
  logic                   cache_req_val;
  logic                   busy;
  cache_pkg::cache_resp_t cache_resp;
  logic                   cache_resp_val;
  cache_pkg::mem_req_t    mem_req;
  logic                   mem_req_val;
  cache_pkg::mem_resp_t   mem_resp;
  logic                   mem_resp_val;

  blocking_cache #(
    .cache_bytes (cache_bytes)
  ) dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .cache_req      (cache_req),
    .cache_req_val  (cache_req_val),
    .busy           (busy),
    .cache_resp     (cache_resp),
    .cache_resp_val (cache_resp_val),
    .mem_req        (mem_req),
    .mem_req_val    (mem_req_val),
    .mem_resp       (mem_resp),
    .mem_resp_val   (mem_resp_val)
  );

  always #2 clk = ~clk;

  int cycle = 0;
  always @(posedge clk) cycle <= cycle + 1;

  // ------------------------------------------------
  // Memory model and reference state
  // ------------------------------------------------

  logic [cache_pkg::line_w-1:0] mem [logic [27:0]];  // Lines written back by the cache
  logic [cache_pkg::data_w-1:0] gold [logic [31:0]]; // Words written by requests
  logic                         sh_valid [nblocks];
  logic                         sh_dirty [nblocks];
  logic [27:0]                  sh_line [nblocks];
  cache_pkg::mem_req_t          exp_mem [$];

  integer seed;
  int     errors;
  int     tests;
  bit     aborted;

  // Untouched memory reads back its own address with a marker on top
  function automatic logic [31:0] default_word(logic [31:0] a);
    return a ^ 32'hC0DE0000;
  endfunction

  function automatic logic [127:0] model_line(logic [27:0] line, bit use_gold);
    logic [127:0] l;
    logic [31:0]  a;
    for (int w = 0; w < cache_pkg::words_per_line; w++) begin
      a = {line, w[1:0], 2'b00};
      l[w*32 +: 32] = (use_gold && gold.exists(a)) ? gold[a] : default_word(a);
    end
    return l;
  endfunction

  task automatic check_resp(input cache_pkg::cache_resp_t exp, input cache_pkg::cache_resp_t act);
    if (act !== exp) begin
      errors++;
      $display("FAILED at %0t ns: resp exp %0d/%h/%h got %0d/%h/%h (type/opq/data)",
               $time, exp.type_, exp.opaque, exp.data, act.type_, act.opaque, act.data);
    end
  endtask

  // Read requests carry no line data
  task automatic check_memreq(input cache_pkg::mem_req_t exp, input cache_pkg::mem_req_t act);
    if (act.type_ !== exp.type_ || act.addr !== exp.addr ||
        (exp.type_ == cache_pkg::req_write && act.data !== exp.data)) begin
      errors++;
      $display("FAILED at %0t ns: mem_req exp %0d @%h data %h",
               $time, exp.type_, exp.addr, exp.data);
      $display("FAILED at %0t ns: mem_req got %0d @%h data %h",
               $time, act.type_, act.addr, act.data);
    end
  endtask

  task automatic check_latency(input int exp, input int act);
    if (act != exp) begin
      errors++;
      $display("FAILED at %0t ns: response after %0d cycles, expected %0d", $time, act, exp);
    end
  endtask

  // Answers one memory request after 1 to 6 cycles
  task automatic serve_mem(input cache_pkg::mem_req_t req);
    cache_pkg::addr_u a;
    int               lat;
    a.raw = req.addr;
    mem_resp.type_ = req.type_;
    if (req.type_ == cache_pkg::req_write) begin
      mem[a.fields.line_addr] = req.data;
      mem_resp.data = '0;
    end else if (mem.exists(a.fields.line_addr)) begin
      mem_resp.data = mem[a.fields.line_addr];
    end else begin
      mem_resp.data = model_line(a.fields.line_addr, 1'b0);
    end
    lat = 1 + ({$random(seed)} % 6);
    repeat (lat) @(negedge clk);
    mem_resp_val = 1'b1;
    @(negedge clk);
    mem_resp_val = 1'b0;
  endtask

  // ------------------------------------------------
  // One request from the file
  // ------------------------------------------------

  task automatic run_test(input string op, input cache_pkg::req_type_e t, input logic [7:0] opq,
                          input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [31:0] expd);
    cache_pkg::addr_u       a;
    logic [idx_w-1:0]       i;
    logic                   fast;
    cache_pkg::mem_req_t    m;
    cache_pkg::cache_resp_t exp_resp;
    int                     t0;
    int                     err0;
    bit                     done;
    string                  verdict;
    a.raw = addr;
    i     = a.fields.line_addr[idx_w-1:0];
    err0  = errors;
    fast  = (t == cache_pkg::req_init) || (sh_valid[i] && sh_line[i] == a.fields.line_addr);
    if (!fast) begin
      if (sh_valid[i] && sh_dirty[i]) begin // Victim goes back first
        m.type_ = cache_pkg::req_write;
        m.addr  = {sh_line[i], 4'h0};
        m.data  = model_line(sh_line[i], 1'b1);
        exp_mem.push_back(m);
      end
      m.type_ = cache_pkg::req_read;
      m.addr  = {a.fields.line_addr, 4'h0};
      m.data  = '0;
      exp_mem.push_back(m);
      sh_dirty[i] = 1'b0;
    end
    sh_valid[i] = 1'b1;
    sh_line[i]  = a.fields.line_addr;
    if (t != cache_pkg::req_read) begin
      sh_dirty[i] = 1'b1;
      gold[{a.raw[31:2], 2'b00}] = wdata;
    end
    exp_resp.type_  = t;
    exp_resp.opaque = opq;
    exp_resp.data   = expd;

    t0 = cycle;
    while (busy && !aborted) begin
      if (cycle - t0 > max_wait) begin
        $display("Timed out waiting for the cache to go idle");
        aborted = 1'b1;
      end else begin
        @(negedge clk);
      end
    end
    if (aborted) return;
    cache_req.type_  = t;
    cache_req.opaque = opq;
    cache_req.addr   = addr;
    cache_req.data   = wdata;
    cache_req_val    = 1'b1;
    @(negedge clk);
    cache_req_val = 1'b0;
    t0   = cycle; // Count from the accepting edge
    done = 1'b0;
    while (!done && !aborted) begin
      if (cycle - t0 > max_wait) begin
        $display("Timed out waiting for a response to opaque %h", opq);
        aborted = 1'b1;
      end else if (mem_req_val) begin
        if (exp_mem.size() == 0) begin
          errors++;
          $display("Unexpected memory request to %h", mem_req.addr);
        end else begin
          check_memreq(exp_mem.pop_front(), mem_req);
        end
        serve_mem(mem_req);
      end else if (cache_resp_val) begin
        check_resp(exp_resp, cache_resp);
        if (fast) check_latency(3, cycle - t0);
        if (busy) begin
          errors++;
          $display("busy still high in the response cycle");
        end
        done = 1'b1;
      end else begin
        @(negedge clk);
      end
    end
    if (aborted) return;
    @(negedge clk);
    if (cache_resp_val) begin
      errors++;
      $display("Response pulse lasted more than one cycle");
    end
    if (exp_mem.size() != 0) begin
      errors++;
      $display("Cache skipped %0d expected memory requests", exp_mem.size());
      exp_mem.delete();
    end
    tests++;
    if (errors == err0) verdict = "ok";
    else verdict = "mismatch";
    $display("case %0d %s opq %h addr %h: %s", tests, op, opq, addr, verdict);
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------

  initial begin
    int                   fd;
    int                   c;
    string                op;
    cache_pkg::req_type_e t;
    logic [7:0]           opq;
    logic [31:0]          addr;
    logic [31:0]          wdata;
    logic [31:0]          expd;
    clk           = 1'b0;
    rst_n         = 1'b0;
    cache_req     = '0;
    cache_req_val = 1'b0;
    mem_resp      = '0;
    mem_resp_val  = 1'b0;
    seed          = 46;
    errors        = 0;
    tests         = 0;
    aborted       = 1'b0;
    for (int b = 0; b < nblocks; b++) begin
      sh_valid[b] = 1'b0;
      sh_dirty[b] = 1'b0;
      sh_line[b]  = '0;
    end
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    fd = $fopen("testbench/cache_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/cache_tests.txt");
      aborted = 1'b1;
    end
    while (!aborted && $fscanf(fd, "%s", op) == 1) begin
      if (op == "#") begin
        c = $fgetc(fd); // Skip the rest of a comment line
        while (c != 10 && c != -1) begin
          c = $fgetc(fd);
        end
      end else if ($fscanf(fd, "%h %h %h %h", opq, addr, wdata, expd) != 4) begin
        $display("Malformed line in the test file after %s", op);
        aborted = 1'b1;
      end else begin
        t = cache_pkg::req_read;
        if (op == "write") t = cache_pkg::req_write;
        else if (op == "init") t = cache_pkg::req_init;
        else if (op != "read") begin
          $display("Unknown operation %s in the test file", op);
          aborted = 1'b1;
        end
        if (!aborted) run_test(op, t, opq, addr, wdata, expd);
      end
    end
    if (fd != 0) $fclose(fd);
    errors += dut.u_sva.fail_count;

    $display("Summary: %0d cases run, %0d errors", tests, errors);
    if (aborted || errors != 0) begin
      $display("TEST FAIL");
    end else begin
      $display("TEST PASS");
    end
    $finish;
  end

endmodule

// File: testbench/cache_sva.sv
/*
 * Protocol assertions for the blocking cache, bound into the top level.
 */

`timescale 1ns/1ps

module cache_sva (
  input logic                  clk,
  input logic                  rst_n,
  input cache_pkg::cache_req_t cache_req,
  input logic                  cache_req_val,
  input logic                  busy,
  input logic                  cache_resp_val,
  input logic                  mem_req_val
);

  int fail_count = 0;

  // Response and memory request never share a cycle
  no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    !(cache_resp_val && mem_req_val))
    else begin
      $error("cache_resp_val and mem_req_val high in the same cycle");
      fail_count++;
    end

  busy_drop: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(busy) |-> cache_resp_val)
    else begin
      $error("busy fell without a response pulse");
      fail_count++;
    end

  // Pulse is set on the third edge after an init is accepted
  init_timing: assert property (@(posedge clk) disable iff (!rst_n)
    (cache_req_val && !busy && cache_req.type_ == cache_pkg::req_init) |=> ##3 cache_resp_val)
    else begin
      $error("init response not three cycles after acceptance");
      fail_count++;
    end

endmodule

bind blocking_cache cache_sva u_sva (
  .clk            (clk),
  .rst_n          (rst_n),
  .cache_req      (cache_req),
  .cache_req_val  (cache_req_val),
  .busy           (busy),
  .cache_resp_val (cache_resp_val),
  .mem_req_val    (mem_req_val)
);

// File: logic/blocking_cache.sv
/*
 * Top level of the direct-mapped write-back cache.
 * Wires the control FSM to the datapath and exposes the strobe ports.
 */

`timescale 1ns/1ps

module blocking_cache #(
  parameter int cache_bytes = 256
) (
  input  logic                   clk,
  input  logic                   rst_n,

  // Processor side
  input  cache_pkg::cache_req_t  cache_req,
  input  logic                   cache_req_val,
  output logic                   busy,
  output cache_pkg::cache_resp_t cache_resp,
  output logic                   cache_resp_val,

  // Memory side, whole lines
  output cache_pkg::mem_req_t    mem_req,
  output logic                   mem_req_val,
  input  cache_pkg::mem_resp_t   mem_resp,
  input  logic                   mem_resp_val
);

  cache_pkg::ctrl_t ctrl;
  cache_pkg::stat_t stat;

  cache_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .cache_req_val  (cache_req_val),
    .mem_resp_val   (mem_resp_val),
    .stat           (stat),
    .ctrl           (ctrl),
    .busy           (busy),
    .cache_resp_val (cache_resp_val),
    .mem_req_val    (mem_req_val)
  );

  cache_dpath #(
    .cache_bytes (cache_bytes)
  ) u_dpath (
    .clk        (clk),
    .rst_n      (rst_n),
    .cache_req  (cache_req),
    .ctrl       (ctrl),
    .mem_resp   (mem_resp),
    .stat       (stat),
    .cache_resp (cache_resp),
    .mem_req    (mem_req)
  );

endmodule

// File: logic/cache_dpath.sv
/*
 * Cache datapath with request capture, tag/valid/dirty and line arrays, refill
 * merge and message packing. All sequencing comes from the ctrl strobes.
 */

`timescale 1ns/1ps

module cache_dpath #(
  parameter int cache_bytes = 256
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cache_pkg::cache_req_t  cache_req,
  input  cache_pkg::ctrl_t       ctrl,
  input  cache_pkg::mem_resp_t   mem_resp,
  output cache_pkg::stat_t       stat,
  output cache_pkg::cache_resp_t cache_resp,
  output cache_pkg::mem_req_t    mem_req
);

  localparam int nblocks    = cache_bytes * 8 / cache_pkg::line_w;
  localparam int idx_w      = $clog2(nblocks);
  localparam int tag_w      = 28 - idx_w; // line_addr bits above the index
  localparam int line_bytes = cache_pkg::line_w / 8;

  // ------------------------------------------------
  // Request capture and address decode
  // ------------------------------------------------

  cache_pkg::cache_req_t req_q;
  cache_pkg::addr_u      req_addr;
  logic [idx_w-1:0]      idx;
  logic [tag_w-1:0]      cur_tag;

  always_ff @(posedge clk) begin
    if (ctrl.req_en) begin
      req_q <= cache_req;
    end
  end

  assign req_addr.raw = req_q.addr;
  assign idx          = req_addr.fields.line_addr[idx_w-1:0];
  assign cur_tag      = req_addr.fields.line_addr[27:idx_w];

  // ------------------------------------------------
  // Arrays
  // ------------------------------------------------

  logic [tag_w-1:0]           tag_array [nblocks];
  logic [cache_pkg::line_w-1:0] data_array [nblocks];
  logic [nblocks-1:0]         valid_q;
  logic [nblocks-1:0]         dirty_q;

  logic [cache_pkg::line_w-1:0] wdata;
  logic [line_bytes-1:0]        byte_en;

  // Word writes go to all four slots and byte enables pick the one
  assign wdata = ctrl.refill_sel ? mem_resp.data
                                 : {cache_pkg::words_per_line{req_q.data}};

  always_comb begin
    if (ctrl.refill_sel) begin
      byte_en = '1; // Whole line from memory
    end else begin
      byte_en = 16'h000f << {req_addr.fields.word_off, 2'b00};
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.data_wen) begin
      for (int b = 0; b < line_bytes; b++) begin
        if (byte_en[b]) begin
          data_array[idx][b*8 +: 8] <= wdata[b*8 +: 8];
        end
      end
    end
    if (ctrl.tag_wen) begin
      tag_array[idx] <= cur_tag;
    end
  end

  // Refill leaves the line clean while a write or init marks it dirty
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (ctrl.tag_wen) begin
      valid_q[idx] <= 1'b1;
      dirty_q[idx] <= !ctrl.refill_sel;
    end
  end

  // Tag check straight off the registered address
  assign stat.hit      = valid_q[idx] && (tag_array[idx] == cur_tag);
  assign stat.dirty    = valid_q[idx] && dirty_q[idx];
  assign stat.req_type = req_q.type_;

  // ------------------------------------------------
  // Read data, evict address, messages
  // ------------------------------------------------

  logic [cache_pkg::line_w-1:0] rdata_q;
  logic [cache_pkg::addr_w-1:0] evict_addr_q;
  cache_pkg::addr_u             evict_addr_d;
  cache_pkg::addr_u             fill_addr;
  logic [cache_pkg::data_w-1:0] rd_word;

  always_ff @(posedge clk) begin
    if (ctrl.data_ren) begin
      rdata_q <= data_array[idx];
    end
  end

  // Victim address is rebuilt from the stored tag
  always_comb begin
    evict_addr_d.fields.line_addr = {tag_array[idx], idx};
    evict_addr_d.fields.word_off  = '0;
    evict_addr_d.fields.byte_off  = '0;
  end

  always_ff @(posedge clk) begin
    if (ctrl.evict_en) begin
      evict_addr_q <= evict_addr_d.raw;
    end
  end

  always_comb begin
    fill_addr                 = req_addr;
    fill_addr.fields.word_off = '0; // Line aligned refill
    fill_addr.fields.byte_off = '0;
  end

  assign mem_req.type_ = ctrl.mem_req_type;
  assign mem_req.addr  = ctrl.mem_addr_sel ? evict_addr_q : fill_addr.raw;
  assign mem_req.data  = rdata_q; // Victim line on evict

  assign rd_word = rdata_q[req_addr.fields.word_off * cache_pkg::data_w +: cache_pkg::data_w];

  // Writes and inits answer with zero data
  always_ff @(posedge clk) begin
    if (ctrl.resp_en) begin
      cache_resp.type_  <= req_q.type_;
      cache_resp.opaque <= req_q.opaque;
      cache_resp.data   <= (req_q.type_ == cache_pkg::req_read) ? rd_word : '0;
    end
  end

endmodule

// File: logic/cache_ctrl.sv
/*
 * Cache control FSM. Sequences tag check, eviction, refill, access and
 * response from the datapath status, and drives the port strobes.
 */

`timescale 1ns/1ps

module cache_ctrl (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cache_req_val,
  input  logic              mem_resp_val,
  input  cache_pkg::stat_t  stat,
  output cache_pkg::ctrl_t  ctrl,
  output logic              busy,
  output logic              cache_resp_val,
  output logic              mem_req_val
);

  typedef enum logic [2:0] {
    idle,
    tag_check,
    evict_req,
    evict_wait,
    refill_req,
    refill_wait,
    access,
    resp
  } state_e;

  state_e state;
  state_e state_next;
  logic   is_init;
  logic   is_read;

  assign is_init = (stat.req_type == cache_pkg::req_init);
  assign is_read = (stat.req_type == cache_pkg::req_read);

  // ------------------------------------------------
  // State register
  // ------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  // Next state
  always_comb begin
    state_next = state;
    case (state)
      idle: begin
        if (cache_req_val) begin
          state_next = tag_check;
        end
      end
      tag_check: begin
        if (stat.hit || is_init) begin
          state_next = access;
        end else if (stat.dirty) begin
          state_next = evict_req; // Old line goes back first
        end else begin
          state_next = refill_req;
        end
      end
      evict_req:  state_next = evict_wait;
      evict_wait: begin
        if (mem_resp_val) begin
          state_next = refill_req;
        end
      end
      refill_req: state_next = refill_wait;
      refill_wait: begin
        if (mem_resp_val) begin
          state_next = access;
        end
      end
      access:  state_next = resp;
      resp:    state_next = idle;
      default: state_next = idle;
    endcase
  end

  // ------------------------------------------------
  // Datapath strobes
  // ------------------------------------------------

  always_comb begin
    ctrl              = '0;
    ctrl.mem_req_type = cache_pkg::req_read;
    case (state)
      idle: begin
        ctrl.req_en = cache_req_val; // Accept only while idle
      end
      tag_check: begin
        // Capture victim line and address ahead of the write back
        if (!stat.hit && !is_init && stat.dirty) begin
          ctrl.data_ren = 1'b1;
          ctrl.evict_en = 1'b1;
        end
      end
      evict_req: begin
        ctrl.mem_addr_sel = 1'b1;
        ctrl.mem_req_type = cache_pkg::req_write;
      end
      evict_wait: begin
        ctrl.mem_addr_sel = 1'b1;
        ctrl.mem_req_type = cache_pkg::req_write;
      end
      refill_wait: begin
        // Line is written in the cycle the memory answers
        ctrl.refill_sel = 1'b1;
        ctrl.data_wen   = mem_resp_val;
        ctrl.tag_wen    = mem_resp_val;
      end
      access: begin
        if (is_read) begin
          ctrl.data_ren = 1'b1;
        end else begin
          ctrl.data_wen = 1'b1; // Write and init
          ctrl.tag_wen  = 1'b1;
        end
      end
      resp: begin
        ctrl.resp_en = 1'b1;
      end
      default: begin
        ctrl.req_en = 1'b0;
      end
    endcase
  end

  // ------------------------------------------------
  // Port strobes
  // ------------------------------------------------

  assign busy        = (state != idle); // Drops together with the response pulse
  assign mem_req_val = (state == evict_req) || (state == refill_req);

  // Registered so it lines up with the response register in the datapath
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cache_resp_val <= 1'b0;
    end else begin
      cache_resp_val <= (state == resp);
    end
  end

endmodule

// File: logic/cache_pkg.sv
/*
 * Shared widths, request types and message structs for the blocking cache.
 * Every RTL and testbench file refers to these by scoped name.
 */

package cache_pkg;

  localparam int addr_w         = 32;
  localparam int data_w         = 32;
  localparam int line_w         = 128;
  localparam int opq_w          = 8;
  localparam int words_per_line = line_w / data_w;

  typedef enum logic [2:0] {
    req_read  = 3'd0,
    req_write = 3'd1,
    req_init  = 3'd2 // Write word and mark valid without memory traffic
  } req_type_e;

  // One address word, seen raw or split into line and offsets
  typedef union packed {
    logic [addr_w-1:0] raw;
    struct packed {
      logic [27:0] line_addr; // Tag and index split by cache size
      logic [1:0]  word_off;
      logic [1:0]  byte_off;
    } fields;
  } addr_u;

  // ------------------------------------------------
  // Processor and memory side messages
  // ------------------------------------------------

  typedef struct packed {
    req_type_e         type_;
    logic [opq_w-1:0]  opaque;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } cache_req_t; // 75 bits

  typedef struct packed {
    req_type_e         type_;
    logic [opq_w-1:0]  opaque;
    logic [data_w-1:0] data;
  } cache_resp_t; // 43 bits

  typedef struct packed {
    req_type_e         type_;
    logic [addr_w-1:0] addr; // Line aligned
    logic [line_w-1:0] data;
  } mem_req_t; // 163 bits

  typedef struct packed {
    req_type_e         type_;
    logic [line_w-1:0] data;
  } mem_resp_t; // 131 bits

  // ------------------------------------------------
  // Control unit to datapath and back
  // ------------------------------------------------

  typedef struct packed {
    logic      req_en;       // Capture the incoming request
    logic      resp_en;      // Load the response register
    logic      tag_wen;      // Write tag, set valid, update dirty
    logic      data_ren;     // Load the read data register
    logic      data_wen;     // Write the data array with byte enables
    logic      refill_sel;   // Write data comes from memory line
    logic      evict_en;     // Capture the victim line address
    logic      mem_addr_sel; // 1 selects evict address
    req_type_e mem_req_type;
  } ctrl_t;

  typedef struct packed {
    logic      hit;   // Valid and tag matches
    logic      dirty; // Indexed line valid and modified
    req_type_e req_type;
  } stat_t;

endpackage
